// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_reservation_station
FILELIST  ?= sim.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: reservation_station.sv
`timescale 1ns/1ps

module reservation_station #(
    parameter int num_alu = 8,
    parameter int num_mem = 4
) (
    input  logic                            clock,
    input  logic                            reset,
    input  rs_pkg::dispatch_t               dispatch,
    input  logic                            enable,
    input  rs_pkg::rob_lookup_t             rob_lookup,
    input  logic [rs_pkg::lsq_idx_bits-1:0] lsq_idx,
    input  rs_pkg::cdb_t                    cdb,
    input  logic                            flush,
    output rs_pkg::issue_t                  issue_out,
    output logic [num_alu+num_mem-1:0]      busy,
    output logic                            read_enable
);

    localparam int num_entries = num_alu + num_mem;

    logic [num_entries-1:0] write;
    logic [num_entries-1:0] grant;
    rs_pkg::entry_t         write_entry;
    rs_pkg::entry_t         entries [num_entries];

    //////////////////////////////////////////////////
    // dispatch -> bank -> issue
    //////////////////////////////////////////////////
    rs_dispatch #(
        .num_alu (num_alu),
        .num_mem (num_mem)
    ) dispatch_i (
        .dispatch    (dispatch),
        .enable      (enable),
        .rob_lookup  (rob_lookup),
        .lsq_idx     (lsq_idx),
        .busy        (busy),
        .write       (write),
        .write_entry (write_entry),
        .read_enable (read_enable)
    );

    rs_bank #(
        .num_alu (num_alu),
        .num_mem (num_mem)
    ) bank_i (
        .clock       (clock),
        .reset       (reset),
        .flush       (flush),
        .write       (write),
        .write_entry (write_entry),
        .cdb         (cdb),
        .grant       (grant),
        .entries     (entries),
        .busy        (busy)
    );

    rs_issue #(
        .num_alu (num_alu),
        .num_mem (num_mem)
    ) issue_i (
        .clock     (clock),
        .reset     (reset),
        .entries   (entries),
        .grant     (grant),
        .issue_out (issue_out)
    );

endmodule

// File: rs_bank.sv
`timescale 1ns/1ps

module rs_bank #(
    parameter int num_alu = 8,
    parameter int num_mem = 4
) (
    input  logic                       clock,
    input  logic                       reset,
    input  logic                       flush,
    input  logic [num_alu+num_mem-1:0] write,
    input  rs_pkg::entry_t             write_entry,
    input  rs_pkg::cdb_t               cdb,
    input  logic [num_alu+num_mem-1:0] grant,
    output rs_pkg::entry_t             entries [num_alu+num_mem],
    output logic [num_alu+num_mem-1:0] busy
);

    localparam int num_entries = num_alu + num_mem;

    //////////////////////////////////////////////////
    // slots
    //////////////////////////////////////////////////
    // alu slots low, memory slots on top
    for (genvar i = 0; i < num_entries; i++) begin : g_slot
        rs_entry slot_i (
            .clock       (clock),
            .reset       (reset),
            .flush       (flush),
            .write       (write[i]),
            .write_entry (write_entry),
            .cdb         (cdb),
            .grant       (grant[i]),
            .entry       (entries[i])
        );

        assign busy[i] = entries[i].busy;
    end

endmodule

// File: rs_dispatch.sv
`timescale 1ns/1ps

module rs_dispatch #(
    parameter int num_alu = 8,
    parameter int num_mem = 4
) (
    input  rs_pkg::dispatch_t                 dispatch,
    input  logic                              enable,
    input  rs_pkg::rob_lookup_t               rob_lookup,
    input  logic [rs_pkg::lsq_idx_bits-1:0]   lsq_idx,
    input  logic [num_alu+num_mem-1:0]        busy,
    output logic [num_alu+num_mem-1:0]        write,
    output rs_pkg::entry_t                    write_entry,
    output logic                              read_enable
);

    localparam int num_entries = num_alu + num_mem;

    // x0, then rob complete, then rob pending, else regfile value
    function automatic rs_pkg::operand_t resolve(
        input logic [rs_pkg::reg_idx_bits-1:0] src,
        input logic                            known,
        input logic                            complete,
        input logic [rs_pkg::tag_bits-1:0]     tag,
        input logic [rs_pkg::xlen-1:0]         rob_value,
        input logic [rs_pkg::xlen-1:0]         rf_value
    );
        rs_pkg::operand_t op;
        op.value   = rf_value;
        op.tag     = '0;
        op.waiting = 1'b0;
        if (src == rs_pkg::zero_reg) begin
            op.value = '0;
        end else if (known && complete) begin
            op.value = rob_value;
        end else if (known) begin
            op.value   = '0;
            op.tag     = tag;
            op.waiting = 1'b1;
        end
        return op;
    endfunction

    logic                   is_mem;
    logic                   alu_free;
    logic                   mem_free;
    logic                   accept;
    logic [num_entries-1:0] alu_pick;
    logic [num_entries-1:0] mem_pick;

    assign is_mem = dispatch.rd_mem || dispatch.wr_mem;

    //////////////////////////////////////////////////
    // free slot search, highest index wins
    //////////////////////////////////////////////////
    always_comb begin
        alu_free = 1'b0;
        mem_free = 1'b0;
        alu_pick = '0;
        mem_pick = '0;
        for (int i = 0; i < num_alu; i++) begin
            if (!busy[i]) begin
                alu_pick    = '0;
                alu_pick[i] = 1'b1;
                alu_free    = 1'b1;
            end
        end
        for (int i = num_alu; i < num_entries; i++) begin
            if (!busy[i]) begin
                mem_pick    = '0;
                mem_pick[i] = 1'b1;
                mem_free    = 1'b1;
            end
        end
    end

    assign accept      = dispatch.valid && enable && (is_mem ? mem_free : alu_free);
    assign write       = accept ? (is_mem ? mem_pick : alu_pick) : '0;
    assign read_enable = alu_free && mem_free;

    always_comb begin
        write_entry.busy     = 1'b1;
        write_entry.issued   = 1'b0;
        write_entry.tag      = rob_lookup.tag;
        write_entry.rs1      = resolve(dispatch.inst.r.rs1, rob_lookup.rs1_known,
                                       rob_lookup.rs1_complete, rob_lookup.rs1_tag,
                                       rob_lookup.rs1_value, dispatch.rs1_value);
        write_entry.rs2      = resolve(dispatch.inst.r.rs2, rob_lookup.rs2_known,
                                       rob_lookup.rs2_complete, rob_lookup.rs2_tag,
                                       rob_lookup.rs2_value, dispatch.rs2_value);
        write_entry.inst     = dispatch.inst;
        write_entry.pc       = dispatch.pc;
        write_entry.rd       = dispatch.rd;
        write_entry.alu_func = dispatch.alu_func;
        write_entry.rd_mem   = dispatch.rd_mem;
        write_entry.wr_mem   = dispatch.wr_mem;
        // alu slots carry no queue index
        write_entry.lsq_idx  = is_mem ? lsq_idx : '0;
    end

    // at most one slot written per cycle
    always_comb begin
        assert ($onehot0(write))
            else $error("dispatch write vector not one-hot");
    end

endmodule

// File: rs_entry.sv
`timescale 1ns/1ps

module rs_entry (
    input  logic           clock,
    input  logic           reset,
    input  logic           flush,
    input  logic           write,
    input  rs_pkg::entry_t write_entry,
    input  rs_pkg::cdb_t   cdb,
    input  logic           grant,
    output rs_pkg::entry_t entry
);

    logic cdb_live;
    logic wake_rs1;
    logic wake_rs2;
    logic done;

    // broadcasts to x0 carry nothing worth waking on
    assign cdb_live = cdb.valid && (cdb.rd != rs_pkg::zero_reg);

    assign wake_rs1 = cdb_live && entry.rs1.waiting && (cdb.tag == entry.rs1.tag);
    assign wake_rs2 = cdb_live && entry.rs2.waiting && (cdb.tag == entry.rs2.tag);

    // own tag on the bus retires an issued slot
    assign done = cdb.valid && entry.issued && (cdb.tag == entry.tag);

    //////////////////////////////////////////////////
    // slot state
    //////////////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (reset || flush) begin
            entry.busy        <= 1'b0;
            entry.issued      <= 1'b0;
            entry.rs1.waiting <= 1'b0;
            entry.rs2.waiting <= 1'b0;
        end else if (write) begin
            // same-cycle broadcast is missed on purpose
            entry <= write_entry;
        end else begin
            if (wake_rs1) begin
                entry.rs1.value   <= cdb.value;
                entry.rs1.waiting <= 1'b0;
            end
            if (wake_rs2) begin
                entry.rs2.value   <= cdb.value;
                entry.rs2.waiting <= 1'b0;
            end
            if (grant) begin
                entry.issued <= 1'b1;
            end
            if (done) begin
                entry.busy   <= 1'b0;
                entry.issued <= 1'b0;
            end
        end
    end

    // issue select must only pick a live, not yet issued slot
    grant_to_pending: assert property (
        @(posedge clock) disable iff (reset)
        grant |-> (entry.busy && !entry.issued)
    ) else $error("grant on a free or already issued entry");

endmodule

// File: rs_issue.sv
`timescale 1ns/1ps

module rs_issue #(
    parameter int num_alu = 8,
    parameter int num_mem = 4
) (
    input  logic                       clock,
    input  logic                       reset,
    input  rs_pkg::entry_t             entries [num_alu+num_mem],
    output logic [num_alu+num_mem-1:0] grant,
    output rs_pkg::issue_t             issue_out
);

    localparam int num_entries = num_alu + num_mem;

    logic [num_entries-1:0] ready;
    rs_pkg::entry_t         winner;
    rs_pkg::issue_t         issue_next;

    always_comb begin
        for (int i = 0; i < num_entries; i++) begin
            ready[i] = entries[i].busy && !entries[i].issued
                    && !entries[i].rs1.waiting && !entries[i].rs2.waiting;
        end
    end

    // last hit in the scan is the highest index
    always_comb begin
        grant  = '0;
        winner = entries[0];
        for (int i = 0; i < num_entries; i++) begin
            if (ready[i]) begin
                grant    = '0;
                grant[i] = 1'b1;
                winner   = entries[i];
            end
        end
    end

    always_comb begin
        issue_next.valid     = |grant;
        issue_next.inst      = winner.inst;
        issue_next.pc        = winner.pc;
        issue_next.rd        = winner.rd;
        issue_next.alu_func  = winner.alu_func;
        issue_next.rd_mem    = winner.rd_mem;
        issue_next.wr_mem    = winner.wr_mem;
        issue_next.tag       = winner.tag;
        issue_next.lsq_idx   = winner.lsq_idx;
        issue_next.rs1_value = winner.rs1.value;
        issue_next.rs2_value = winner.rs2.value;
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            issue_out.valid <= 1'b0;
        end else begin
            issue_out <= issue_next;
        end
    end

    one_grant: assert property (
        @(posedge clock) disable iff (reset)
        $onehot0(grant)
    ) else $error("more than one entry granted");

endmodule

// File: rs_pkg.sv
package rs_pkg;

    //////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////
    localparam int xlen         = 32;
    localparam int tag_bits     = 5;
    localparam int lsq_idx_bits = 3;
    localparam int reg_idx_bits = 5;

    localparam logic [reg_idx_bits-1:0] zero_reg = '0;

    //////////////////////////////////////////////////
    // instruction word
    //////////////////////////////////////////////////
    // raw view is stored, R-format view feeds source decode
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [6:0]              funct7;
            logic [reg_idx_bits-1:0] rs2;
            logic [reg_idx_bits-1:0] rs1;
            logic [2:0]              funct3;
            logic [reg_idx_bits-1:0] rd;
            logic [6:0]              opcode;
        } r;
    } inst_word_t;

    //////////////////////////////////////////////////
    // packets
    //////////////////////////////////////////////////
    typedef struct packed {
        logic                    valid;
        inst_word_t              inst;
        logic [xlen-1:0]         pc;
        logic [reg_idx_bits-1:0] rd;
        logic [4:0]              alu_func;
        logic                    rd_mem;
        logic                    wr_mem;
        logic [xlen-1:0]         rs1_value;
        logic [xlen-1:0]         rs2_value;
    } dispatch_t;

    // reorder buffer view of the instruction in dispatch
    typedef struct packed {
        logic [tag_bits-1:0] tag;
        logic                rs1_known;
        logic                rs1_complete;
        logic [tag_bits-1:0] rs1_tag;
        logic [xlen-1:0]     rs1_value;
        logic                rs2_known;
        logic                rs2_complete;
        logic [tag_bits-1:0] rs2_tag;
        logic [xlen-1:0]     rs2_value;
    } rob_lookup_t;

    typedef struct packed {
        logic                    valid;
        logic [tag_bits-1:0]     tag;
        logic [reg_idx_bits-1:0] rd;
        logic [xlen-1:0]         value;
    } cdb_t;

    typedef struct packed {
        logic [xlen-1:0]     value;
        logic [tag_bits-1:0] tag;
        logic                waiting;
    } operand_t;

    typedef struct packed {
        logic                    busy;
        logic                    issued;
        logic [tag_bits-1:0]     tag;
        operand_t                rs1;
        operand_t                rs2;
        inst_word_t              inst;
        logic [xlen-1:0]         pc;
        logic [reg_idx_bits-1:0] rd;
        logic [4:0]              alu_func;
        logic                    rd_mem;
        logic                    wr_mem;
        logic [lsq_idx_bits-1:0] lsq_idx;
    } entry_t;

    typedef struct packed {
        logic                    valid;
        inst_word_t              inst;
        logic [xlen-1:0]         pc;
        logic [reg_idx_bits-1:0] rd;
        logic [4:0]              alu_func;
        logic                    rd_mem;
        logic                    wr_mem;
        logic [tag_bits-1:0]     tag;
        logic [lsq_idx_bits-1:0] lsq_idx;
        logic [xlen-1:0]         rs1_value;
        logic [xlen-1:0]         rs2_value;
    } issue_t;

endpackage

// File: sim.f
rs_pkg.sv
rs_dispatch.sv
rs_entry.sv
rs_bank.sv
rs_issue.sv
reservation_station.sv
tb_reservation_station.sv

// File: tb_reservation_station.sv
`timescale 1ns/1ps

module tb_reservation_station;

    localparam int num_alu         = 8;
    localparam int num_mem         = 4;
    localparam int num_entries     = num_alu + num_mem;
    localparam int reset_cycles    = 5;
    localparam int directed_cycles = 60;
    localparam int drain_cycles    = 40;
    localparam int drain_count     = 5;
    localparam int random_cycles   = 3000;
    localparam int total_cycles    = reset_cycles + directed_cycles
                                   + drain_count * drain_cycles + random_cycles;

    logic                            clock      = 1'b0;
    logic                            reset      = 1'b1;
    rs_pkg::dispatch_t               dispatch   = '0;
    logic                            enable     = 1'b0;
    rs_pkg::rob_lookup_t             rob_lookup = '0;
    logic [rs_pkg::lsq_idx_bits-1:0] lsq_idx    = '0;
    rs_pkg::cdb_t                    cdb        = '0;
    logic                            flush      = 1'b0;
    rs_pkg::issue_t                  issue_out;
    logic [num_entries-1:0]          busy;
    logic                            read_enable;

    // reference model state
    rs_pkg::entry_t                  m [num_entries];
    rs_pkg::issue_t                  exp_issue;
    logic [31:0]                     lfsr     = 32'he1dd;
    logic [rs_pkg::tag_bits-1:0]     next_tag = '0;

    reservation_station #(
        .num_alu (num_alu),
        .num_mem (num_mem)
    ) reservation_station_i (
        .clock       (clock),
        .reset       (reset),
        .dispatch    (dispatch),
        .enable      (enable),
        .rob_lookup  (rob_lookup),
        .lsq_idx     (lsq_idx),
        .cdb         (cdb),
        .flush       (flush),
        .issue_out   (issue_out),
        .busy        (busy),
        .read_enable (read_enable)
    );

    always #4 clock = ~clock;

    initial begin
        #(total_cycles * 8 + 400);
        $display("watchdog: the run did not finish in time, simulation hung");
        $display("Simulation finished: FAIL");
        $fatal(1, "watchdog timeout");
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    // galois lfsr stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
            r    = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    task automatic compare(input string name, input logic [63:0] actual,
                           input logic [63:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h at %0t",
                     name, actual, expected, $time);
            $display("Simulation finished: FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // x0 first, then rob complete, then rob pending, else regfile
    function automatic rs_pkg::operand_t expect_operand(
        input logic [4:0] src, input logic known, input logic complete,
        input logic [4:0] tag, input logic [31:0] rob_value, input logic [31:0] rf_value
    );
        rs_pkg::operand_t op;
        op = '0;
        if (src == 5'd0) begin
            op.value = '0;
        end else if (known && complete) begin
            op.value = rob_value;
        end else if (known) begin
            op.tag     = tag;
            op.waiting = 1'b1;
        end else begin
            op.value = rf_value;
        end
        return op;
    endfunction

    // kind 0 regfile, 1 rob complete, 2 rob pending
    task automatic set_dispatch(input logic mem, input logic [4:0] rs1, input logic [4:0] rs2,
                                input int kind1, input int kind2,
                                input logic [4:0] tag1, input logic [4:0] tag2);
        dispatch.valid          = 1'b1;
        dispatch.inst.raw       = rand_bits(32);
        dispatch.inst.r.rs1     = rs1;
        dispatch.inst.r.rs2     = rs2;
        dispatch.pc             = rand_bits(32);
        dispatch.rd             = dispatch.inst.r.rd;
        dispatch.alu_func       = 5'(rand_bits(5));
        dispatch.rd_mem         = mem && rand_bits(1) == 32'd1;
        dispatch.wr_mem         = mem && !dispatch.rd_mem;
        dispatch.rs1_value      = rand_bits(32);
        dispatch.rs2_value      = rand_bits(32);
        rob_lookup.tag          = next_tag;
        rob_lookup.rs1_known    = kind1 != 0;
        rob_lookup.rs1_complete = kind1 == 1;
        rob_lookup.rs1_tag      = tag1;
        rob_lookup.rs1_value    = rand_bits(32);
        rob_lookup.rs2_known    = kind2 != 0;
        rob_lookup.rs2_complete = kind2 == 1;
        rob_lookup.rs2_tag      = tag2;
        rob_lookup.rs2_value    = rand_bits(32);
        lsq_idx                 = 3'(rand_bits(3));
        next_tag                = next_tag + 1'b1;
    endtask

    // only tags that something waits on, or tags of issued entries
    task automatic pick_broadcast(input logic random_pick);
        logic [rs_pkg::tag_bits-1:0] cands [$];
        int                          k;
        for (int i = 0; i < num_entries; i++) begin
            if (m[i].busy && m[i].rs1.waiting) cands.push_back(m[i].rs1.tag);
            if (m[i].busy && m[i].rs2.waiting) cands.push_back(m[i].rs2.tag);
            if (m[i].issued) cands.push_back(m[i].tag);
        end
        if (cands.size() > 0) begin
            k         = random_pick ? int'(rand_bits(8)) % cands.size() : 0;
            cdb.valid = 1'b1;
            cdb.tag   = cands[k];
            cdb.rd    = (random_pick && rand_bits(3) == 32'd0) ? 5'd0
                                                               : 5'(rand_bits(5) | 32'd1);
            cdb.value = rand_bits(32);
        end
    endtask

    //////////////////////////////////////////////////
    // reference model stepped once per rising edge
    //////////////////////////////////////////////////
    task automatic model_advance();
        rs_pkg::entry_t   nxt [num_entries];
        rs_pkg::operand_t op1;
        rs_pkg::operand_t op2;
        logic             mem;
        int               win;
        int               slot;
        win  = -1;
        slot = -1;
        mem  = dispatch.rd_mem || dispatch.wr_mem;
        op1  = expect_operand(dispatch.inst.r.rs1, rob_lookup.rs1_known, rob_lookup.rs1_complete,
                              rob_lookup.rs1_tag, rob_lookup.rs1_value, dispatch.rs1_value);
        op2  = expect_operand(dispatch.inst.r.rs2, rob_lookup.rs2_known, rob_lookup.rs2_complete,
                              rob_lookup.rs2_tag, rob_lookup.rs2_value, dispatch.rs2_value);
        for (int i = 0; i < num_entries; i++) begin
            if (m[i].busy && !m[i].issued && !m[i].rs1.waiting && !m[i].rs2.waiting) win = i;
            if (dispatch.valid && enable && !m[i].busy && (mem == (i >= num_alu))) slot = i;
        end
        exp_issue.valid = 1'b0;
        if (win >= 0) begin
            exp_issue = '{1'b1, m[win].inst, m[win].pc, m[win].rd, m[win].alu_func,
                          m[win].rd_mem, m[win].wr_mem, m[win].tag, m[win].lsq_idx,
                          m[win].rs1.value, m[win].rs2.value};
        end
        for (int i = 0; i < num_entries; i++) begin
            nxt[i] = m[i];
            if (i == slot) begin
                nxt[i] = '{1'b1, 1'b0, rob_lookup.tag, op1, op2, dispatch.inst, dispatch.pc,
                           dispatch.rd, dispatch.alu_func, dispatch.rd_mem, dispatch.wr_mem,
                           mem ? lsq_idx : 3'd0};
            end else begin
                if (cdb.valid && cdb.rd != 5'd0 && m[i].rs1.waiting
                        && cdb.tag == m[i].rs1.tag) begin
                    nxt[i].rs1 = '{cdb.value, m[i].rs1.tag, 1'b0};
                end
                if (cdb.valid && cdb.rd != 5'd0 && m[i].rs2.waiting
                        && cdb.tag == m[i].rs2.tag) begin
                    nxt[i].rs2 = '{cdb.value, m[i].rs2.tag, 1'b0};
                end
                if (i == win) nxt[i].issued = 1'b1;
                if (cdb.valid && m[i].issued && cdb.tag == m[i].tag) begin
                    nxt[i].busy   = 1'b0;
                    nxt[i].issued = 1'b0;
                end
            end
            if (flush) begin
                nxt[i].busy        = 1'b0;
                nxt[i].issued      = 1'b0;
                nxt[i].rs1.waiting = 1'b0;
                nxt[i].rs2.waiting = 1'b0;
            end
        end
        m = nxt;
    endtask

    task automatic check_outputs();
        logic [num_entries-1:0] exp_busy;
        for (int i = 0; i < num_entries; i++) exp_busy[i] = m[i].busy;
        compare("busy", 64'(busy), 64'(exp_busy));
        compare("read_enable", 64'(read_enable),
                64'(!(&exp_busy[num_alu-1:0]) && !(&exp_busy[num_entries-1:num_alu])));
        compare("issue_out.valid", 64'(issue_out.valid), 64'(exp_issue.valid));
        if (exp_issue.valid) begin
            compare("issue_out.inst", 64'(issue_out.inst.raw), 64'(exp_issue.inst.raw));
            compare("issue_out.pc", 64'(issue_out.pc), 64'(exp_issue.pc));
            compare("issue_out.rd", 64'(issue_out.rd), 64'(exp_issue.rd));
            compare("issue_out.alu_func", 64'(issue_out.alu_func), 64'(exp_issue.alu_func));
            compare("issue_out.rd_mem", 64'(issue_out.rd_mem), 64'(exp_issue.rd_mem));
            compare("issue_out.wr_mem", 64'(issue_out.wr_mem), 64'(exp_issue.wr_mem));
            compare("issue_out.tag", 64'(issue_out.tag), 64'(exp_issue.tag));
            compare("issue_out.lsq_idx", 64'(issue_out.lsq_idx), 64'(exp_issue.lsq_idx));
            compare("issue_out.rs1_value", 64'(issue_out.rs1_value), 64'(exp_issue.rs1_value));
            compare("issue_out.rs2_value", 64'(issue_out.rs2_value), 64'(exp_issue.rs2_value));
        end
    endtask

    // inputs are set at a falling edge, the model steps, then the next falling edge checks
    task automatic tick();
        model_advance();
        @(negedge clock);
        check_outputs();
        dispatch.valid = 1'b0;
        cdb.valid      = 1'b0;
        flush          = 1'b0;
    endtask

    task automatic drain();
        repeat (drain_cycles) begin
            pick_broadcast(1'b0);
            tick();
        end
    endtask

    //////////////////////////////////////////////////
    // test sequence
    //////////////////////////////////////////////////
    initial begin
        for (int i = 0; i < num_entries; i++) m[i] = '0;
        exp_issue = '0;
        repeat (reset_cycles) @(negedge clock);
        reset  = 1'b0;
        enable = 1'b1;
        check_outputs();

        // ready sources, regfile value with x0, then a rob complete value
        set_dispatch(1'b0, 5'd4, 5'd0, 0, 0, '0, '0);
        tick();
        tick();
        compare("issue_out.valid", 64'(issue_out.valid), 64'd1);
        compare("issue_out.rs1_value", 64'(issue_out.rs1_value), 64'(dispatch.rs1_value));
        compare("issue_out.rs2_value", 64'(issue_out.rs2_value), 64'd0);
        set_dispatch(1'b1, 5'd7, 5'd9, 1, 0, '0, '0);
        tick();
        tick();
        compare("issue_out.rs1_value", 64'(issue_out.rs1_value), 64'(rob_lookup.rs1_value));
        drain();

        // pending sources that an x0 broadcast must not wake
        set_dispatch(1'b0, 5'd3, 5'd5, 2, 2, 5'd20, 5'd21);
        repeat (3) tick();
        cdb = '{1'b1, 5'd20, 5'd0, 32'h0bad_0bad};
        tick();
        cdb = '{1'b1, 5'd20, 5'd3, 32'h1111_2222};
        tick();
        cdb = '{1'b1, 5'd21, 5'd5, 32'h3333_4444};
        tick();
        tick();
        compare("issue_out.rs1_value", 64'(issue_out.rs1_value), 64'h1111_2222);
        compare("issue_out.rs2_value", 64'(issue_out.rs2_value), 64'h3333_4444);
        drain();

        // five entries woken together with memory ones first
        for (int i = 0; i < 5; i++) begin
            set_dispatch(i >= 3, 5'(i + 1), 5'd0, 2, 0, 5'd12, '0);
            tick();
        end
        cdb = '{1'b1, 5'd12, 5'd1, 32'h5555_aaaa};
        repeat (7) tick();
        drain();

        // extra alu dispatch dropped once the alu group is full
        for (int i = 0; i < num_alu + 1; i++) begin
            set_dispatch(1'b0, 5'd6, 5'd0, 2, 0, 5'd30, '0);
            tick();
        end
        compare("read_enable", 64'(read_enable), 64'd0);
        set_dispatch(1'b1, 5'd0, 5'd0, 0, 0, '0, '0);
        repeat (3) tick();
        // another tag on the bus leaves the issued memory entry busy
        cdb = '{1'b1, 5'd30, 5'd2, 32'h7777_0000};
        tick();
        compare("busy[top]", 64'(busy[num_entries-1]), 64'd1);
        drain();

        // flush wins over a dispatch in the same cycle
        set_dispatch(1'b0, 5'd2, 5'd0, 2, 0, 5'd8, '0);
        tick();
        set_dispatch(1'b1, 5'd0, 5'd0, 0, 0, '0, '0);
        flush = 1'b1;
        tick();
        compare("busy", 64'(busy), 64'd0);
        repeat (4) tick();

        // random mix
        repeat (random_cycles) begin
            set_dispatch(rand_bits(2) == 32'd0,
                         rand_bits(2) == 32'd0 ? 5'd0 : 5'(rand_bits(5)),
                         rand_bits(2) == 32'd0 ? 5'd0 : 5'(rand_bits(5)),
                         int'(rand_bits(2) % 3), int'(rand_bits(2) % 3),
                         5'(rand_bits(5)), 5'(rand_bits(5)));
            dispatch.valid = rand_bits(2) != 32'd0;
            enable         = rand_bits(3) != 32'd0;
            flush          = rand_bits(7) == 32'd0;
            if (rand_bits(1) == 32'd1) pick_broadcast(1'b1);
            tick();
        end
        enable = 1'b1;
        drain();

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule
